// File: list.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/access_if.sv
hdl/pipe_reg.sv
hdl/decode_stage.sv
hdl/access_stage.sv
hdl/plic_regs.sv
hdl/soc_bus_top.sv
verification/tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bus_pkg.sv
      - hdl/periph_pkg.sv
      - hdl/access_if.sv
      - hdl/pipe_reg.sv
      - hdl/decode_stage.sv
      - hdl/access_stage.sv
      - hdl/plic_regs.sv
      - hdl/soc_bus_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/tb_soc_bus.sv

// File: verification/tb_soc_bus.sv
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module tb_soc_bus;
    import bus_pkg::*;

    // request budget for the watchdog above what the tests issue
    localparam int MAX_REQUESTS = 200;
    localparam int WATCHDOG_NS  = (MAX_REQUESTS * 40 + 500) * 40;
    localparam int WAIT_LIMIT   = 1000;
    // ram offset for the burst clear of the round trip bytes
    localparam int BURST_OFF    = 256;

    logic        CLOCK_50;
    logic        KEY0;
    logic        req_valid;
    logic        req_ready;
    logic [63:0] req_addr;
    logic        req_write;
    logic [2:0]  req_ls_type;
    logic [63:0] req_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [63:0] rsp_rdata;
    logic        rsp_err;
    logic        ext_irq;
    logic        meip;
    logic        seip;
    logic        timer_irq;

    integer      seed;
    int          errors;
    int          checks;
    logic        saw_stall;
    // little endian byte image of the low ram
    logic [7:0]  model [0:511];

    soc_bus_top i_soc_bus_top (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_write(req_write), .req_ls_type(req_ls_type), .req_wdata(req_wdata),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
        .rsp_err(rsp_err), .ext_irq(ext_irq), .meip(meip), .seip(seip),
        .timer_irq(timer_irq)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, expected);
        end
    endtask

    function automatic int bytes_of(input ls_type_e ls);
        case (ls)
            LS_B, LS_BU: return 1;
            LS_H, LS_HU: return 2;
            LS_W, LS_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    task automatic store_model(input int off, input ls_type_e ls, input logic [63:0] data);
        for (int i = 0; i < bytes_of(ls); i++) begin
            model[off + i] = data[8*i +: 8];
        end
    endtask

    // gather the bytes then sign extend for lb, lh and lw
    function automatic logic [63:0] expected_load(input int off, input ls_type_e ls);
        logic [63:0] v;
        int          n;
        v = '0;
        n = bytes_of(ls);
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model[off + i];
        end
        if (ls == LS_B || ls == LS_H || ls == LS_W) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = v[8*n - 1];
            end
        end
        return v;
    endfunction

    // starts on a falling edge and returns on the one after the beat
    task automatic send_req(input logic [63:0] addr, input logic write,
                            input ls_type_e ls, input logic [63:0] wdata);
        logic ready_now;
        int   waited;
        waited      = 0;
        req_valid   = 1'b1;
        req_addr    = addr;
        req_write   = write;
        req_ls_type = ls;
        req_wdata   = wdata;
        do begin
            // ready only moves on the rising edge
            ready_now = req_ready;
            if (!ready_now) begin
                saw_stall = 1'b1;
            end
            @(negedge CLOCK_50);
            waited++;
        end while (!ready_now && waited < WAIT_LIMIT);
        req_valid = 1'b0;
        if (!ready_now) begin
            errors++;
            $display("request to %h was never accepted", addr);
        end
    endtask

    task automatic recv_rsp(input logic random_ready, output logic [63:0] rdata,
                            output logic err);
        logic fired;
        int   waited;
        waited = 0;
        do begin
            rsp_ready = random_ready ? (($random(seed) & 32'h1) != 0) : 1'b1;
            fired     = rsp_valid && rsp_ready;
            rdata     = rsp_rdata;
            err       = rsp_err;
            @(negedge CLOCK_50);
            waited++;
        end while (!fired && waited < WAIT_LIMIT);
        rsp_ready = 1'b0;
        if (!fired) begin
            errors++;
            $display("no response arrived within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic transact(input logic [63:0] addr, input logic write, input ls_type_e ls,
                            input logic [63:0] wdata, output logic [63:0] rdata,
                            output logic err);
        send_req(addr, write, ls, wdata);
        recv_rsp(1'b0, rdata, err);
    endtask

    task automatic read_check(input logic [63:0] addr, input ls_type_e ls,
                              input logic [63:0] expected);
        logic [63:0] rdata;
        logic        err;
        transact(addr, 1'b0, ls, '0, rdata, err);
        check_value("rsp_rdata", rdata, expected);
        check_value("rsp_err", err, 1'b0);
    endtask

    task automatic write_ok(input logic [63:0] addr, input ls_type_e ls,
                            input logic [63:0] data);
        logic [63:0] rdata;
        logic        err;
        transact(addr, 1'b1, ls, data, rdata, err);
        check_value("rsp_err", err, 1'b0);
    endtask

    task automatic store_ram(input int off, input ls_type_e ls, input logic [63:0] data);
        store_model(off, ls, data);
        write_ok(`RAM_BASE + off, ls, data);
    endtask

    task automatic expect_error(input logic [63:0] addr, input logic write, input ls_type_e ls);
        logic [63:0] rdata;
        logic        err;
        transact(addr, write, ls, 64'hdead_beef_dead_beef, rdata, err);
        check_value("rsp_err", err, 1'b1);
        check_value("rsp_rdata", rdata, '0);
    endtask

    task automatic ram_round_trip();
        ls_type_e types [7] = '{LS_B, LS_H, LS_W, LS_D, LS_BU, LS_HU, LS_WU};
        store_ram(0, LS_D, {$random(seed), $random(seed)});
        // negative word and half so the extension shows
        store_ram(8, LS_W, 64'h0000_0000_8765_43a1);
        store_ram(12, LS_H, 64'h0000_0000_0000_f00d);
        store_ram(14, LS_H, 64'h0000_0000_0000_7e12);
        for (int i = 16; i < 24; i++) begin
            store_ram(i, LS_B, $random(seed));
        end
        // every aligned load type over all written bytes
        for (int off = 0; off < 24; off++) begin
            for (int t = 0; t < 7; t++) begin
                if (off % bytes_of(types[t]) == 0) begin
                    read_check(`RAM_BASE + off, types[t], expected_load(off, types[t]));
                end
            end
        end
    endtask

    task automatic invalid_access();
        expect_error(64'h0000_0000_0000_1000, 1'b0, LS_W);
        expect_error(64'h0000_0000_4000_0000, 1'b1, LS_D);
        expect_error(`RAM_BASE + 2, 1'b0, LS_W);
        expect_error(`RAM_BASE + 1, 1'b0, LS_HU);
        // doubles need 8 byte alignment
        expect_error(`RAM_BASE + 4, 1'b0, LS_D);
    endtask

    task automatic timer_regs();
        logic [63:0] t1;
        logic [63:0] t2;
        logic        err;
        read_check(`MTIMECMP_ADDR, LS_D, `MTIMECMP_RESET);
        write_ok(`MTIMECMP_ADDR, LS_D, 64'h0000_0012_3456_789a);
        read_check(`MTIMECMP_ADDR, LS_D, 64'h0000_0012_3456_789a);
        check_value("timer_irq", timer_irq, 1'b0);
        transact(`MTIME_ADDR, 1'b0, LS_D, '0, t1, err);
        transact(`MTIME_ADDR, 1'b0, LS_D, '0, t2, err);
        check_value("mtime increasing", t2 > t1, 1'b1);
        // compare value already passed
        write_ok(`MTIMECMP_ADDR, LS_D, t2 - 64'd1);
        check_value("timer_irq", timer_irq, 1'b1);
    endtask

    task automatic plic_flow();
        // two sources and two contexts written before any read back
        write_ok(`PLIC_BASE + 4, LS_W, 64'd5);
        write_ok(`PLIC_BASE + 8, LS_W, 64'd2);
        read_check(`PLIC_BASE + 4, LS_W, 64'd5);
        read_check(`PLIC_BASE + 8, LS_W, 64'd2);
        write_ok(`PLIC_ENABLE, LS_W, 64'd2);
        read_check(`PLIC_ENABLE, LS_W, 64'd2);
        write_ok(`PLIC_THRESHOLD, LS_W, 64'd3);
        write_ok(`PLIC_THRESHOLD + `PLIC_CTX_STRIDE, LS_W, 64'd1);
        read_check(`PLIC_THRESHOLD, LS_W, 64'd3);
        read_check(`PLIC_THRESHOLD + `PLIC_CTX_STRIDE, LS_W, 64'd1);
        read_check(`PLIC_PENDING, LS_W, 64'd0);
        // one cycle pulse on the external line
        ext_irq = 1'b1;
        @(negedge CLOCK_50);
        ext_irq = 1'b0;
        @(negedge CLOCK_50);
        check_value("meip", meip, 1'b1);
        check_value("seip", seip, 1'b0);
        read_check(`PLIC_PENDING, LS_W, 64'd2);
        write_ok(`PLIC_ENABLE + `PLIC_ENABLE_STRIDE, LS_W, 64'd2);
        read_check(`PLIC_ENABLE + `PLIC_ENABLE_STRIDE, LS_W, 64'd2);
        check_value("seip", seip, 1'b1);
        write_ok(`PLIC_ENABLE + `PLIC_ENABLE_STRIDE, LS_W, 64'd0);
        check_value("seip", seip, 1'b0);
        // machine line drops with its enable while source 1 stays pending
        write_ok(`PLIC_ENABLE, LS_W, 64'd0);
        check_value("meip", meip, 1'b0);
        write_ok(`PLIC_ENABLE, LS_W, 64'd2);
        check_value("meip", meip, 1'b1);
        // claim on context 0 retires source 1
        read_check(`PLIC_CLAIM, LS_W, 64'd1);
        read_check(`PLIC_PENDING, LS_W, 64'd0);
        check_value("meip", meip, 1'b0);
    endtask

    task automatic back_pressure_burst();
        logic [63:0] expect_q [$];
        logic        write_q [$];
        logic [63:0] data;
        logic [63:0] rdata;
        logic        err;
        logic        was_write;
        int          off;
        ls_type_e    ls;
        saw_stall = 1'b0;
        fork
            begin
                // eight double writes then reads of the same words
                for (int i = 0; i < 16; i++) begin
                    off = BURST_OFF + 8 * (i % 8) + ((i >= 8 && i % 2 == 1) ? 4 : 0);
                    if (i < 8) begin
                        data = {$random(seed), $random(seed)};
                        store_model(off, LS_D, data);
                        expect_q.push_back('0);
                        write_q.push_back(1'b1);
                        send_req(`RAM_BASE + off, 1'b1, LS_D, data);
                    end else begin
                        ls = (i % 2 == 1) ? LS_WU : LS_D;
                        expect_q.push_back(expected_load(off, ls));
                        write_q.push_back(1'b0);
                        send_req(`RAM_BASE + off, 1'b0, ls, '0);
                    end
                end
            end
            begin
                // response side shut until the pipeline is full
                repeat (10) @(negedge CLOCK_50);
                for (int i = 0; i < 16; i++) begin
                    recv_rsp(1'b1, rdata, err);
                    was_write = write_q.pop_front();
                    data      = expect_q.pop_front();
                    check_value("rsp_err", err, 1'b0);
                    if (!was_write) begin
                        check_value("rsp_rdata", rdata, data);
                    end
                end
            end
        join
        check_value("req_ready low seen", saw_stall, 1'b1);
    endtask

    initial begin
        seed        = 32'h1c17;
        errors      = 0;
        checks      = 0;
        saw_stall   = 1'b0;
        KEY0        = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_write   = 1'b0;
        req_ls_type = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        ext_irq     = 1'b0;
        repeat (3) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        // idle state straight out of reset
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("req_ready", req_ready, 1'b1);
        check_value("meip", meip, 1'b0);
        check_value("seip", seip, 1'b0);
        check_value("timer_irq", timer_irq, 1'b0);
        ram_round_trip();
        invalid_access();
        timer_regs();
        plic_flow();
        back_pressure_burst();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [63:0] req_addr,
    input  logic        req_write,
    input  logic [2:0]  req_ls_type,
    input  logic [63:0] req_wdata,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [63:0] rsp_rdata,
    output logic        rsp_err,
    input  logic        ext_irq,
    output logic        meip,
    output logic        seip,
    output logic        timer_irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    bus_req_t  req_in;
    bus_req_t  req_q;
    logic      req_q_valid;
    logic      req_q_ready;
    bus_rsp_t  rsp_d;
    logic      rsp_d_valid;
    logic      rsp_d_ready;
    bus_rsp_t  rsp_q;
    logic      plic_sel;
    logic      plic_write;
    plic_reg_e plic_reg;
    logic      plic_ctx;
    logic [2:0]  plic_id;
    logic [31:0] plic_wdata;
    logic [31:0] plic_rdata;

    access_if acc ();

    assign req_in.addr    = req_addr;
    assign req_in.write   = req_write;
    assign req_in.ls_type = ls_type_e'(req_ls_type);
    assign req_in.wdata   = req_wdata;

    // stage 1, input register
    pipe_reg #(.payload_t(bus_req_t)) req_reg (
        .CLOCK_50 (CLOCK_50),  .KEY0      (KEY0),
        .in_valid (req_valid), .in_ready  (req_ready),   .in_data  (req_in),
        .out_valid(req_q_valid), .out_ready(req_q_ready), .out_data(req_q)
    );

    // stage 2, address decode
    decode_stage i_decode (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0),
        .in_valid(req_q_valid), .in_ready(req_q_ready), .in_data(req_q),
        .acc     (acc.src)
    );

    // stage 3, target access
    access_stage i_access (
        .CLOCK_50  (CLOCK_50),    .KEY0      (KEY0),        .acc       (acc.dst),
        .out_valid (rsp_d_valid), .out_ready (rsp_d_ready), .out_data  (rsp_d),
        .plic_sel  (plic_sel),    .plic_write(plic_write),  .plic_reg  (plic_reg),
        .plic_ctx  (plic_ctx),    .plic_id   (plic_id),     .plic_wdata(plic_wdata),
        .plic_rdata(plic_rdata),  .timer_irq (timer_irq)
    );

    plic_regs i_plic (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0),
        .sel     (plic_sel), .write(plic_write), .reg_sel(plic_reg),
        .ctx     (plic_ctx), .id   (plic_id),    .wdata  (plic_wdata), .rdata(plic_rdata),
        .ext_irq (ext_irq),  .meip (meip),       .seip   (seip)
    );

    // response register toward the master
    pipe_reg #(.payload_t(bus_rsp_t)) rsp_reg (
        .CLOCK_50 (CLOCK_50),    .KEY0      (KEY0),
        .in_valid (rsp_d_valid), .in_ready  (rsp_d_ready), .in_data (rsp_d),
        .out_valid(rsp_valid),   .out_ready (rsp_ready),   .out_data(rsp_q)
    );

    assign rsp_rdata = rsp_q.rdata;
    assign rsp_err   = rsp_q.err;

endmodule

// File: hdl/plic_regs.sv
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module plic_regs (
    input  logic                             CLOCK_50,
    input  logic                             KEY0,
    input  logic                             sel,
    input  logic                             write,
    input  periph_pkg::plic_reg_e            reg_sel,
    input  logic                             ctx,
    input  logic [$clog2(`PLIC_SOURCES)-1:0] id,
    input  logic [31:0]                      wdata,
    output logic [31:0]                      rdata,
    input  logic                             ext_irq,
    output logic                             meip,
    output logic                             seip
);
    import periph_pkg::*;

    localparam int N = `PLIC_SOURCES;

    logic [2:0]   prio [N];
    logic [N-1:0] pending;
    // context 0 machine, context 1 supervisor
    logic [N-1:0] enable [2];
    logic [2:0]   threshold [2];
    logic         ext_d;
    logic         ext_rise;
    logic [1:0]   claim_hit;

    assign ext_rise = ext_irq && !ext_d;

    // claim looks at source 1 only, priority and threshold not used
    assign claim_hit[0] = pending[1] && enable[0][1];
    assign claim_hit[1] = pending[1] && enable[1][1];
    assign meip = claim_hit[0];
    assign seip = claim_hit[1];

    always_comb begin
        case (reg_sel)
            PREG_PRIORITY:  rdata = {29'd0, prio[id]};
            PREG_PENDING:   rdata = 32'(pending);
            PREG_ENABLE:    rdata = 32'(enable[ctx]);
            PREG_THRESHOLD: rdata = {29'd0, threshold[ctx]};
            PREG_CLAIM:     rdata = {31'd0, claim_hit[ctx]};
            default:        rdata = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ext_d   <= 1'b0;
            pending <= '0;
            for (int i = 0; i < N; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            ext_d <= ext_irq;
            if (sel && write) begin
                case (reg_sel)
                    PREG_PRIORITY:  prio[id]       <= wdata[2:0];
                    PREG_ENABLE:    enable[ctx]    <= wdata[N-1:0];
                    PREG_THRESHOLD: threshold[ctx] <= wdata[2:0];
                    default:        ;
                endcase
            end
            // read of claim completes the interrupt
            if (sel && !write && reg_sel == PREG_CLAIM && claim_hit[ctx]) begin
                pending[1] <= 1'b0;
            end
            // a new edge wins over a claim in the same cycle
            if (ext_rise) begin
                pending[1] <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/access_stage.sv
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module access_stage (
    input  logic                             CLOCK_50,
    input  logic                             KEY0,
    access_if.dst                            acc,
    output logic                             out_valid,
    input  logic                             out_ready,
    output bus_pkg::bus_rsp_t                out_data,
    output logic                             plic_sel,
    output logic                             plic_write,
    output periph_pkg::plic_reg_e            plic_reg,
    output logic                             plic_ctx,
    output logic [$clog2(`PLIC_SOURCES)-1:0] plic_id,
    output logic [31:0]                      plic_wdata,
    input  logic [31:0]                      plic_rdata,
    output logic                             timer_irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int WORD_AW = $clog2(`RAM_WORDS);

    logic [31:0]        ram [`RAM_WORDS];
    logic [63:0]        mtime;
    logic [63:0]        mtimecmp;
    // high word pass of ld/sd
    logic               step;
    logic [31:0]        lo_word;
    logic               go;
    logic               is_double;
    logic               last;
    logic [WORD_AW-1:0] waddr;
    logic [1:0]         off;
    logic [31:0]        word;
    logic [31:0]        shifted;
    logic [3:0]         lane_en;
    logic [31:0]        lane_data;
    logic [63:0]        rdata_next;

    assign is_double = acc.target == TGT_RAM && !acc.err && acc.req.ls_type == LS_D;
    assign last      = !is_double || step;
    // work only when the result register can take the answer
    assign go        = acc.valid && (!out_valid || out_ready);
    assign acc.ready = (!out_valid || out_ready) && last;

    assign waddr   = step ? acc.word_index + 1'b1 : acc.word_index;
    assign off     = acc.req.addr[1:0];
    assign word    = ram[waddr];
    assign shifted = word >> {off, 3'b000};

    // interrupt controller sits outside, strobe for one cycle
    assign plic_sel   = go && acc.target == TGT_PLIC && !acc.err;
    assign plic_write = acc.req.write;
    assign plic_reg   = acc.plic_reg;
    assign plic_ctx   = acc.plic_ctx;
    assign plic_id    = acc.plic_id;
    assign plic_wdata = acc.req.wdata[31:0];

    assign timer_irq = mtime >= mtimecmp;

    // store lanes, narrow data replicated over the word
    always_comb begin
        case (acc.req.ls_type)
            LS_B: begin
                lane_en   = 4'b0001 << off;
                lane_data = {4{acc.req.wdata[7:0]}};
            end
            LS_H: begin
                lane_en   = 4'b0011 << off;
                lane_data = {2{acc.req.wdata[15:0]}};
            end
            LS_D: begin
                lane_en   = 4'b1111;
                lane_data = step ? acc.req.wdata[63:32] : acc.req.wdata[31:0];
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = acc.req.wdata[31:0];
            end
        endcase
    end

    // load data, aligned down and extended
    always_comb begin
        case (acc.target)
            TGT_RAM: begin
                case (acc.req.ls_type)
                    LS_B:    rdata_next = {{56{shifted[7]}}, shifted[7:0]};
                    LS_H:    rdata_next = {{48{shifted[15]}}, shifted[15:0]};
                    LS_W:    rdata_next = {{32{shifted[31]}}, shifted};
                    LS_D:    rdata_next = {word, lo_word};
                    LS_BU:   rdata_next = {56'd0, shifted[7:0]};
                    LS_HU:   rdata_next = {48'd0, shifted[15:0]};
                    default: rdata_next = {32'd0, shifted};
                endcase
            end
            TGT_MTIME:    rdata_next = mtime;
            TGT_MTIMECMP: rdata_next = mtimecmp;
            TGT_PLIC:     rdata_next = {32'd0, plic_rdata};
            default:      rdata_next = '0;
        endcase
        // stores and errors answer with zero
        if (acc.err || acc.req.write) begin
            rdata_next = '0;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            out_valid <= 1'b0;
            step      <= 1'b0;
            mtime     <= '0;
            mtimecmp  <= `MTIMECMP_RESET;
        end else begin
            mtime <= mtime + 64'd1;
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (go) begin
                step <= !last;
                if (last) begin
                    out_valid <= 1'b1;
                end
                if (acc.target == TGT_MTIMECMP && acc.req.write && !acc.err) begin
                    mtimecmp <= acc.req.wdata;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (go) begin
            if (!last) begin
                lo_word <= word;
            end else begin
                out_data.rdata <= rdata_next;
                out_data.err   <= acc.err;
            end
            if (acc.target == TGT_RAM && !acc.err && acc.req.write) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_en[i]) begin
                        ram[waddr][8*i +: 8] <= lane_data[8*i +: 8];
                    end
                end
            end
        end
    end

    // decode alignment keeps the second word inside the ram
    double_in_range: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        acc.valid && is_double && !step |-> acc.word_index != `RAM_WORDS - 1
    );

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module decode_stage (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              in_valid,
    output logic              in_ready,
    input  bus_pkg::bus_req_t in_data,
    access_if.src             acc
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int WORD_AW = $clog2(`RAM_WORDS);
    localparam int ID_W    = $clog2(`PLIC_SOURCES);

    logic [63:0] addr;
    logic [63:0] ram_off;
    target_e     target;
    plic_reg_e   preg;
    logic        ctx;
    logic        misaligned;

    assign addr     = in_data.addr;
    assign ram_off  = addr - `RAM_BASE;
    // output slot free or leaving this cycle
    assign in_ready = !acc.valid || acc.ready;

    // memory map compare
    always_comb begin
        target = TGT_NONE;
        preg   = PREG_PRIORITY;
        ctx    = 1'b0;
        if (addr >= `RAM_BASE && ram_off < 4 * `RAM_WORDS) begin
            target = TGT_RAM;
        end else if (addr == `MTIME_ADDR) begin
            target = TGT_MTIME;
        end else if (addr == `MTIMECMP_ADDR) begin
            target = TGT_MTIMECMP;
        end else if (addr >= `PLIC_BASE && addr < `PLIC_BASE + 4 * `PLIC_SOURCES
                     && addr[1:0] == 2'b00) begin
            target = TGT_PLIC;
        end else if (addr == `PLIC_PENDING) begin
            target = TGT_PLIC;
            preg   = PREG_PENDING;
        end else if (addr == `PLIC_ENABLE || addr == `PLIC_ENABLE + `PLIC_ENABLE_STRIDE) begin
            target = TGT_PLIC;
            preg   = PREG_ENABLE;
            ctx    = addr[7];
        end else if (addr == `PLIC_THRESHOLD || addr == `PLIC_THRESHOLD + `PLIC_CTX_STRIDE) begin
            target = TGT_PLIC;
            preg   = PREG_THRESHOLD;
            ctx    = addr[12];
        end else if (addr == `PLIC_CLAIM || addr == `PLIC_CLAIM + `PLIC_CTX_STRIDE) begin
            target = TGT_PLIC;
            preg   = PREG_CLAIM;
            ctx    = addr[12];
        end
    end

    // natural alignment, doubles on 8 bytes so both words stay in range
    always_comb begin
        case (in_data.ls_type)
            LS_B, LS_BU: misaligned = 1'b0;
            LS_H, LS_HU: misaligned = addr[0];
            LS_W, LS_WU: misaligned = addr[1:0] != 2'b00;
            LS_D:        misaligned = addr[2:0] != 3'b000;
            default:     misaligned = 1'b1;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            acc.valid <= 1'b0;
        end else if (in_ready) begin
            acc.valid <= in_valid;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (in_valid && in_ready) begin
            acc.req        <= in_data;
            acc.target     <= target;
            acc.plic_reg   <= preg;
            acc.plic_ctx   <= ctx;
            // priority slot is offset / 4
            acc.plic_id    <= addr[ID_W+1:2];
            acc.word_index <= ram_off[WORD_AW+1:2];
            acc.err        <= target == TGT_NONE || (target == TGT_RAM && misaligned);
        end
    end

endmodule

// File: hdl/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     spare_valid;
    payload_t spare_data;
    logic     main_free;
    logic     in_fire;

    // ready only looks at the spare slot, no path from out_ready
    assign in_ready  = !spare_valid;
    assign in_fire   = in_valid && in_ready;
    assign main_free = !out_valid || out_ready;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            // spare drains first, otherwise take the new beat
            out_valid   <= spare_valid || in_fire;
            spare_valid <= 1'b0;
        end else if (in_fire) begin
            // output stalled, park the beat
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (main_free) begin
            out_data <= spare_valid ? spare_data : in_data;
        end else if (in_fire) begin
            spare_data <= in_data;
        end
    end

    // stalled beat must not change under the consumer
    hold_when_stalled: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        out_valid && !out_ready |=> $stable(out_data)
    );

endmodule

// File: hdl/access_if.sv
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

interface access_if;
    import bus_pkg::*;
    import periph_pkg::*;

    logic                              valid;
    logic                              ready;
    bus_req_t                          req;
    target_e                           target;
    plic_reg_e                         plic_reg;
    logic                              plic_ctx;
    logic [$clog2(`PLIC_SOURCES)-1:0]  plic_id;
    // ram word of the first (or only) access
    logic [$clog2(`RAM_WORDS)-1:0]     word_index;
    // unmapped or misaligned, answered without touching a target
    logic                              err;

    modport src (
        output valid, req, target, plic_reg, plic_ctx, plic_id, word_index, err,
        input  ready
    );

    modport dst (
        input  valid, req, target, plic_reg, plic_ctx, plic_id, word_index, err,
        output ready
    );

endinterface

// File: hdl/periph_pkg.sv
package periph_pkg;

    // which target a decoded request goes to
    typedef enum logic [2:0] {
        TGT_NONE     = 3'd0,
        TGT_RAM      = 3'd1,
        TGT_MTIME    = 3'd2,
        TGT_MTIMECMP = 3'd3,
        TGT_PLIC     = 3'd4
    } target_e;

    // register group inside the interrupt controller
    typedef enum logic [2:0] {
        PREG_PRIORITY  = 3'd0,
        PREG_PENDING   = 3'd1,
        PREG_ENABLE    = 3'd2,
        PREG_THRESHOLD = 3'd3,
        PREG_CLAIM     = 3'd4
    } plic_reg_e;

endpackage

// File: hdl/bus_pkg.sv
package bus_pkg;

    // load/store size code as the cpu encodes it
    // stores only use the signed codes
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

    // one load or store from the master
    typedef struct packed {
        logic [63:0] addr;
        logic        write;
        ls_type_e    ls_type;
        logic [63:0] wdata;
    } bus_req_t;

    // one response per request, in order
    typedef struct packed {
        logic [63:0] rdata;
        logic        err;
    } bus_rsp_t;

endpackage

// File: hdl/soc_bus_consts.svh
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

// on-chip ram window
`define RAM_BASE           64'h0000_0000_8000_0000
`define RAM_WORDS          1024

// machine timer registers
`define MTIME_ADDR         64'h0000_0000_0200_BFF8
`define MTIMECMP_ADDR      64'h0000_0000_0200_4000
// far enough out that the timer stays quiet after reset
`define MTIMECMP_RESET     64'h0000_0000_8000_0000

// interrupt controller map
`define PLIC_BASE          64'h0000_0000_0C00_0000
`define PLIC_PENDING       64'h0000_0000_0C00_1000
`define PLIC_ENABLE        64'h0000_0000_0C00_2000
`define PLIC_ENABLE_STRIDE 64'h0000_0000_0000_0080
`define PLIC_THRESHOLD     64'h0000_0000_0C20_0000
`define PLIC_CLAIM         64'h0000_0000_0C20_0004
`define PLIC_CTX_STRIDE    64'h0000_0000_0000_1000
// source ids 0..5, only id 1 is wired
`define PLIC_SOURCES       6

`endif
